//--- build.f
design/instr_decode_pkg.sv
design/decoded_instr_if.sv
design/instr_queue.sv
design/instr_decoder.sv
design/reg_scoreboard.sv
design/issue_ctrl.sv
design/decode_stage_top.sv
verif/decode_stage_checker.sv
verif/tb_decode_stage.sv

//--- verif/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;
	timeunit 1ns;
	timeprecision 100ps;

	// five tests of well under 200 cycles each
	localparam int TIMEOUT_CYCLES = 2000;

	typedef struct packed {
		logic [2:0]                 group;
		instr_decode_pkg::oper_t    oper;
		instr_decode_pkg::reg_idx_t ra;
		instr_decode_pkg::reg_idx_t rb;
		instr_decode_pkg::reg_idx_t rc;
		instr_decode_pkg::imm_t     imm;
		logic                       forced_64;
		logic                       branch;
	} exp_t;

	logic                          clk;
	logic                          arst_n;
	logic                          in_valid;
	instr_decode_pkg::instr_t      in_instr;
	logic                          in_credit;
	logic                          out_valid;
	instr_decode_pkg::group_t      out_group;
	instr_decode_pkg::oper_t       out_oper;
	instr_decode_pkg::reg_idx_t    out_ra;
	instr_decode_pkg::reg_idx_t    out_rb;
	instr_decode_pkg::reg_idx_t    out_rc;
	instr_decode_pkg::imm_t        out_imm;
	logic                          out_forced_64;
	logic                          exec_credit;
	logic                          branch_done;
	logic                          wb_valid;
	instr_decode_pkg::reg_idx_t    wb_idx;

	exp_t                          exp_q[$];
	instr_decode_pkg::reg_idx_t    wb_q[$];
	int fetch_cred;
	int words_sent;
	int credits_back;
	int issued;
	int exec_owed;
	int cycles;
	int checks;
	int errors;
	logic auto_credit;
	logic auto_wb;
	logic auto_branch;
	logic branch_owed;

	decode_stage_top u_decode_stage_top (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_instr      (in_instr),
		.in_credit     (in_credit),
		.out_valid     (out_valid),
		.out_group     (out_group),
		.out_oper      (out_oper),
		.out_ra        (out_ra),
		.out_rb        (out_rb),
		.out_rc        (out_rc),
		.out_imm       (out_imm),
		.out_forced_64 (out_forced_64),
		.exec_credit   (exec_credit),
		.branch_done   (branch_done),
		.wb_valid      (wb_valid),
		.wb_idx        (wb_idx)
	);

	bind decode_stage_top decode_stage_checker u_checker (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.in_credit   (in_credit),
		.out_valid   (out_valid),
		.exec_credit (exec_credit)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// alu, load and store share one layout with bit 12 unused
	function automatic instr_decode_pkg::instr_t alu_word(input logic [2:0] grp,
		input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc,
		input logic [3:0] op, input logic [11:0] imm);
		return {grp, ra, rb, rc, op, 1'b0, imm};
	endfunction

	function automatic instr_decode_pkg::instr_t branch_word(input logic [3:0] ra,
		input logic [3:0] op, input logic [19:0] imm);
		return {3'd1, ra, op, 1'b0, imm};
	endfunction

	function automatic logic model_nop(input instr_decode_pkg::instr_t w);
		case (w[31:29])
		3'd0: return w[16:13] > 4'd12;
		3'd1: return w[24:21] > 4'd2;
		3'd2, 3'd3: return w[16:13] > 4'd8;
		default: return 1'b1;
		endcase
	endfunction

	function automatic exp_t model_decode(input instr_decode_pkg::instr_t w);
		exp_t e;
		logic [3:0] op;
		e = '0;
		e.group = w[31:29];
		e.ra = w[28:25];
		if (w[31:29] == 3'd1)
		begin
			e.branch = 1'b1;
			e.oper = w[24:21];
			e.imm = {{44{w[19]}}, w[19:0]};
		end
		else
		begin
			op = w[16:13];
			e.oper = op;
			e.rb = w[24:21];
			e.rc = w[20:17];
			e.imm = {{52{w[11]}}, w[11:0]};
			e.forced_64 = (w[31:29] == 3'd0)
				&& (op == 4'd6 || op == 4'd8 || op == 4'd9 || op == 4'd11);
		end
		return e;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_output();
		exp_t e;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("out_valid came with no instruction outstanding");
		end
		else
		begin
			e = exp_q.pop_front();
			check_val("out_group", out_group, e.group);
			check_val("out_oper", out_oper, e.oper);
			check_val("out_ra", out_ra, e.ra);
			if (!e.branch)
			begin
				check_val("out_rb", out_rb, e.rb);
				check_val("out_rc", out_rc, e.rc);
			end
			check_val("out_imm", out_imm, e.imm);
			check_val("out_forced_64", out_forced_64, e.forced_64);
			issued++;
			exec_owed++;
			if (auto_wb && (e.group == 3'd0 || e.group == 3'd2))
				wb_q.push_back(e.ra);
			if (auto_branch && e.branch)
				branch_owed = 1'b1;
		end
	endtask

	// execute stand-in samples at the edge and answers just after it
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d instructions never issued",
				TIMEOUT_CYCLES, exp_q.size());
			$display("TEST FAIL");
			$finish;
		end
		else
		begin
			if (in_credit)
			begin
				fetch_cred++;
				credits_back++;
			end
			if (out_valid)
				check_output();
			#2;
			exec_credit = 1'b0;
			wb_valid = 1'b0;
			branch_done = 1'b0;
			if (auto_credit && exec_owed > 0)
			begin
				exec_credit = 1'b1;
				exec_owed--;
			end
			if (wb_q.size() > 0)
			begin
				wb_valid = 1'b1;
				wb_idx = wb_q.pop_front();
			end
			if (branch_owed)
			begin
				branch_done = 1'b1;
				branch_owed = 1'b0;
			end
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	// fetch side only sends while it holds a credit
	task automatic send_word(input instr_decode_pkg::instr_t w);
		while (fetch_cred == 0)
			wait_cycles(1);
		in_valid = 1'b1;
		in_instr = w;
		fetch_cred--;
		words_sent++;
		if (!model_nop(w))
			exp_q.push_back(model_decode(w));
		wait_cycles(1);
		in_valid = 1'b0;
	endtask

	task automatic wait_issued(input int n);
		while (issued < n)
			wait_cycles(1);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || wb_q.size() != 0)
			wait_cycles(1);
		wait_cycles(3);
		check_val("fetch credits", fetch_cred, instr_decode_pkg::QUEUE_DEPTH);
	endtask

	task automatic test_group_decode();
		logic [2:0] grp;
		logic [3:0] op;
		logic [3:0] wide_ops[4];
		wide_ops = '{4'd6, 4'd8, 4'd9, 4'd11};
		for (int i = 0; i < 24; i++)
		begin
			grp = 3'($urandom_range(3, 0));
			case (grp)
			3'd0: op = 4'($urandom_range(12, 0));
			3'd1: op = 4'($urandom_range(2, 0));
			default: op = 4'($urandom_range(8, 0));
			endcase
			if (grp == 3'd1)
				send_word(branch_word(4'($urandom), op, 20'($urandom)));
			else
				send_word(alu_word(grp, 4'($urandom), 4'($urandom), 4'($urandom), op,
					12'($urandom)));
		end
		foreach (wide_ops[i])
			send_word(alu_word(3'd0, 4'(i + 1), 4'd0, 4'd0, wide_ops[i], 12'h800));
		wait_drain();
	endtask

	task automatic test_nop_drop();
		int base_sent;
		int base_cred;
		int base_issued;
		base_sent = words_sent;
		base_cred = credits_back;
		base_issued = issued;
		for (int op = 13; op < 16; op++)
			send_word(alu_word(3'd0, 4'd1, 4'd2, 4'd3, 4'(op), 12'($urandom)));
		for (int op = 3; op < 16; op += 4)
			send_word(branch_word(4'd0, 4'(op), 20'($urandom)));
		for (int g = 2; g < 4; g++)
		begin
			send_word(alu_word(3'(g), 4'd4, 4'd0, 4'd0, 4'd9, 12'h0));
			send_word(alu_word(3'(g), 4'd4, 4'd0, 4'd0, 4'd15, 12'h0));
		end
		for (int g = 4; g < 8; g++)
			send_word({3'(g), 29'($urandom)});
		send_word(alu_word(3'd0, 4'd7, 4'd0, 4'd0, 4'd1, 12'h123));
		wait_drain();
		check_val("issued count", issued, base_issued + 1);
		check_val("in_credit count", credits_back - base_cred, words_sent - base_sent);
	endtask

	task automatic test_reg_hazard();
		int base;
		base = issued;
		auto_wb = 1'b0;
		send_word(alu_word(3'd2, 4'd5, 4'd0, 4'd0, 4'd0, 12'h010));
		send_word(alu_word(3'd0, 4'd6, 4'd5, 4'd0, 4'd0, 12'h001));
		wait_issued(base + 1);
		wait_cycles(10);
		check_val("issued count", issued, base + 1);
		auto_wb = 1'b1;
		wb_q.push_back(4'd5);
		wait_drain();
		check_val("issued count", issued, base + 2);
	endtask

	task automatic test_branch_wait();
		int base;
		base = issued;
		auto_branch = 1'b0;
		send_word(branch_word(4'd0, 4'd2, 20'hffff0));
		send_word(alu_word(3'd0, 4'd1, 4'd2, 4'd3, 4'd1, 12'h7ff));
		send_word(alu_word(3'd2, 4'd4, 4'd0, 4'd0, 4'd3, 12'hffe));
		wait_issued(base + 1);
		wait_cycles(10);
		check_val("issued count", issued, base + 1);
		auto_branch = 1'b1;
		branch_owed = 1'b1;
		wait_drain();
		check_val("issued count", issued, base + 3);
	endtask

	task automatic test_credit_backpressure();
		int base;
		base = issued;
		auto_credit = 1'b0;
		for (int i = 1; i <= 6; i++)
			send_word(alu_word(3'd0, 4'(i), 4'd0, 4'd0, 4'd2, 12'(i)));
		wait_cycles(10);
		check_val("issued count", issued, base + instr_decode_pkg::EXEC_CREDITS);
		auto_credit = 1'b1;
		wait_drain();
		check_val("issued count", issued, base + 6);
	endtask

	initial
	begin
		void'($urandom(73));
		arst_n = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		exec_credit = 1'b0;
		branch_done = 1'b0;
		wb_valid = 1'b0;
		wb_idx = '0;
		fetch_cred = instr_decode_pkg::QUEUE_DEPTH;
		words_sent = 0;
		credits_back = 0;
		issued = 0;
		exec_owed = 0;
		cycles = 0;
		checks = 0;
		errors = 0;
		auto_credit = 1'b1;
		auto_wb = 1'b1;
		auto_branch = 1'b1;
		branch_owed = 1'b0;
		// a clean falling edge well before the first clock edge
		#1;
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;
		wait_cycles(2);

		test_group_decode();
		test_nop_drop();
		test_reg_hazard();
		test_branch_wait();
		test_credit_backpressure();

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			u_decode_stage_top.u_checker.fail_count);
		if (errors == 0 && u_decode_stage_top.u_checker.fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/decode_stage_checker.sv
`default_nettype none

module decode_stage_checker (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic in_credit,
	input logic out_valid,
	input logic exec_credit
);
	timeunit 1ns;
	timeprecision 100ps;

	// credits the execute side has handed out, as seen from the ports
	int exec_avail;
	// words taken in and not yet credited back
	int words_held;
	int fail_count = 0;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exec_avail <= instr_decode_pkg::EXEC_CREDITS;
			words_held <= 0;
		end
		else
		begin
			exec_avail <= exec_avail + int'(exec_credit) - int'(out_valid);
			words_held <= words_held + int'(in_valid) - int'(in_credit);
		end
	end

	out_low_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
	else
	begin
		fail_count++;
		$error("out_valid high while in reset");
	end

	out_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> (exec_avail > 0))
	else
	begin
		fail_count++;
		$error("out_valid with no execute credit left");
	end

	credit_needs_word: assert property (@(posedge clk) disable iff (!arst_n)
		in_credit |-> (words_held > 0))
	else
	begin
		fail_count++;
		$error("in_credit without a word taken in");
	end

endmodule

`default_nettype wire

//--- design/decode_stage_top.sv
`default_nettype none

module decode_stage_top (
	input  logic                       clk,
	input  logic                       arst_n,

	// fetch side
	input  logic                       in_valid,
	input  instr_decode_pkg::instr_t   in_instr,
	output logic                       in_credit,

	// execute side
	output logic                       out_valid,
	output instr_decode_pkg::group_t   out_group,
	output instr_decode_pkg::oper_t    out_oper,
	output instr_decode_pkg::reg_idx_t out_ra,
	output instr_decode_pkg::reg_idx_t out_rb,
	output instr_decode_pkg::reg_idx_t out_rc,
	output instr_decode_pkg::imm_t     out_imm,
	output logic                       out_forced_64,
	input  logic                       exec_credit,
	input  logic                       branch_done,
	input  logic                       wb_valid,
	input  instr_decode_pkg::reg_idx_t wb_idx
);

	logic                     pop;
	logic                     head_valid;
	instr_decode_pkg::instr_t head_instr;
	logic                     hazard;
	logic                     set_en;

	decoded_instr_if dec_if ();

	instr_queue u_instr_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.pop        (pop),
		.head_valid (head_valid),
		.head_instr (head_instr),
		.in_credit  (in_credit)
	);

	instr_decoder u_instr_decoder (
		.instr (head_instr),
		.dec   (dec_if.dec)
	);

	// the head's ra is the register an issued instruction will write
	reg_scoreboard u_reg_scoreboard (
		.clk      (clk),
		.arst_n   (arst_n),
		.set_en   (set_en),
		.set_idx  (dec_if.ra),
		.wb_valid (wb_valid),
		.wb_idx   (wb_idx),
		.ra       (dec_if.ra),
		.rb       (dec_if.rb),
		.rc       (dec_if.rc),
		.hazard   (hazard)
	);

	issue_ctrl u_issue_ctrl (
		.clk           (clk),
		.arst_n        (arst_n),
		.head_valid    (head_valid),
		.dec           (dec_if.ctrl),
		.hazard        (hazard),
		.exec_credit   (exec_credit),
		.branch_done   (branch_done),
		.pop           (pop),
		.set_en        (set_en),
		.out_valid     (out_valid),
		.out_group     (out_group),
		.out_oper      (out_oper),
		.out_ra        (out_ra),
		.out_rb        (out_rb),
		.out_rc        (out_rc),
		.out_imm       (out_imm),
		.out_forced_64 (out_forced_64)
	);

endmodule

`default_nettype wire

//--- design/issue_ctrl.sv
`default_nettype none

module issue_ctrl (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          head_valid,
	decoded_instr_if.ctrl                 dec,
	input  logic                          hazard,
	input  logic                          exec_credit,
	input  logic                          branch_done,
	output logic                          pop,
	output logic                          set_en,
	output logic                          out_valid,
	output instr_decode_pkg::group_t      out_group,
	output instr_decode_pkg::oper_t       out_oper,
	output instr_decode_pkg::reg_idx_t    out_ra,
	output instr_decode_pkg::reg_idx_t    out_rb,
	output instr_decode_pkg::reg_idx_t    out_rc,
	output instr_decode_pkg::imm_t        out_imm,
	output logic                          out_forced_64
);

	instr_decode_pkg::ctrl_state_t state;
	instr_decode_pkg::ctrl_state_t state_nxt;
	instr_decode_pkg::credit_cnt_t credits;
	logic                          running;
	logic                          issue;
	logic                          drop;

	assign running = (state == instr_decode_pkg::st_run);

	assign issue = head_valid && !dec.nop && running && (credits != '0) && !hazard;
	assign drop = head_valid && dec.nop && running;
	assign pop = issue || drop;

	// alu and load results go back to a register
	assign set_en = issue && ((dec.group == instr_decode_pkg::group_alu)
		|| (dec.group == instr_decode_pkg::group_load));

	always_comb
	begin
		state_nxt = state;
		case (state)
		instr_decode_pkg::st_run:
		begin
			// only branches end in ex
			if (issue && (dec.stall_type == instr_decode_pkg::stall_ends_in_ex))
				state_nxt = instr_decode_pkg::st_branch_wait;
		end
		instr_decode_pkg::st_branch_wait:
		begin
			if (branch_done)
				state_nxt = instr_decode_pkg::st_run;
		end
		default: state_nxt = instr_decode_pkg::st_run;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= instr_decode_pkg::st_run;
			credits <= instr_decode_pkg::credit_cnt_t'(instr_decode_pkg::EXEC_CREDITS);
			out_valid <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			case ({exec_credit, issue})
			2'b10: credits <= credits + 1'b1;
			2'b01: credits <= credits - 1'b1;
			default: credits <= credits;
			endcase
			out_valid <= issue;
		end
	end

	// payload only moves on issue
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			out_group <= dec.group;
			out_oper <= dec.oper;
			out_ra <= dec.ra;
			out_rb <= dec.rb;
			out_rc <= dec.rc;
			out_imm <= dec.imm;
			out_forced_64 <= dec.forced_64;
		end
	end

endmodule

`default_nettype wire

//--- design/reg_scoreboard.sv
`default_nettype none

module reg_scoreboard (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       set_en,
	input  instr_decode_pkg::reg_idx_t set_idx,
	input  logic                       wb_valid,
	input  instr_decode_pkg::reg_idx_t wb_idx,
	input  instr_decode_pkg::reg_idx_t ra,
	input  instr_decode_pkg::reg_idx_t rb,
	input  instr_decode_pkg::reg_idx_t rc,
	output logic                       hazard
);

	logic [instr_decode_pkg::NUM_REGS-1:0] pending;
	logic [instr_decode_pkg::NUM_REGS-1:0] clr_mask;
	logic [instr_decode_pkg::NUM_REGS-1:0] live;

	always_comb
	begin
		clr_mask = '0;
		if (wb_valid)
			clr_mask[wb_idx] = 1'b1;
	end

	// a write landing this cycle already counts as done
	assign live = pending & ~clr_mask;
	assign hazard = live[ra] | live[rb] | live[rc];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pending <= '0;
		else
		begin
			pending <= live;
			// a new writer wins over a writeback to the same register
			if (set_en)
				pending[set_idx] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`default_nettype none

module instr_decoder (
	input  instr_decode_pkg::instr_t instr,
	decoded_instr_if.dec             dec
);

	instr_decode_pkg::group_t   grp;
	instr_decode_pkg::oper_t    alu_oper;
	instr_decode_pkg::oper_t    br_oper;
	instr_decode_pkg::reg_idx_t ra_field;
	instr_decode_pkg::imm_t     simm12_ext;
	instr_decode_pkg::imm_t     simm20_ext;

	assign grp = instr_decode_pkg::group_t'(
		instr[instr_decode_pkg::GROUP_MSB:instr_decode_pkg::GROUP_LSB]);
	assign alu_oper = instr[instr_decode_pkg::OPER_MSB:instr_decode_pkg::OPER_LSB];
	assign br_oper = instr[instr_decode_pkg::BR_OPER_MSB:instr_decode_pkg::BR_OPER_LSB];
	assign ra_field = instr[instr_decode_pkg::RA_MSB:instr_decode_pkg::RA_LSB];

	// top bit of the field copied up to 64 bits
	assign simm12_ext = {
		{(instr_decode_pkg::IMM_WIDTH - instr_decode_pkg::SIMM12_MSB - 1)
			{instr[instr_decode_pkg::SIMM12_MSB]}},
		instr[instr_decode_pkg::SIMM12_MSB:0]};
	assign simm20_ext = {
		{(instr_decode_pkg::IMM_WIDTH - instr_decode_pkg::SIMM20_MSB - 1)
			{instr[instr_decode_pkg::SIMM20_MSB]}},
		instr[instr_decode_pkg::SIMM20_MSB:0]};

	assign dec.group = grp;
	assign dec.ra = ra_field;

	assign dec.forced_64 = (grp == instr_decode_pkg::group_alu)
		&& ((alu_oper == instr_decode_pkg::oper_div)
		|| (alu_oper == instr_decode_pkg::oper_shl)
		|| (alu_oper == instr_decode_pkg::oper_shr)
		|| (alu_oper == instr_decode_pkg::oper_not));

	always_comb
	begin
		dec.oper = alu_oper;
		dec.rb = instr[instr_decode_pkg::RB_MSB:instr_decode_pkg::RB_LSB];
		dec.rc = instr[instr_decode_pkg::RC_MSB:instr_decode_pkg::RC_LSB];
		dec.imm = simm12_ext;
		dec.nop = 1'b1;
		dec.stall_type = instr_decode_pkg::stall_none;

		case (grp)
		instr_decode_pkg::group_alu:
		begin
			// 13 and 14 are unassigned as well
			dec.nop = (alu_oper == instr_decode_pkg::oper_bad_alu)
				|| (alu_oper > instr_decode_pkg::ALU_OPER_LAST);
		end
		instr_decode_pkg::group_branch:
		begin
			dec.oper = br_oper;
			// no rb or rc here, so only ra is looked up
			dec.rb = ra_field;
			dec.rc = ra_field;
			dec.imm = simm20_ext;
			dec.nop = !((br_oper == instr_decode_pkg::oper_bnz)
				|| (br_oper == instr_decode_pkg::oper_bzo)
				|| (br_oper == instr_decode_pkg::oper_jmp));
			dec.stall_type = instr_decode_pkg::stall_ends_in_ex;
		end
		instr_decode_pkg::group_load:
		begin
			dec.nop = alu_oper[3] && (alu_oper != instr_decode_pkg::oper_ld_f16);
			dec.stall_type = instr_decode_pkg::stall_ends_in_wb;
		end
		instr_decode_pkg::group_store:
		begin
			dec.nop = alu_oper[3] && (alu_oper != instr_decode_pkg::oper_st_f16);
			dec.stall_type = instr_decode_pkg::stall_ends_in_wb;
		end
		default:
		begin
			dec.oper = '0;
			dec.imm = '0;
		end
		endcase
	end

endmodule

`default_nettype wire

//--- design/instr_queue.sv
`default_nettype none

module instr_queue (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  instr_decode_pkg::instr_t in_instr,
	input  logic                     pop,
	output logic                     head_valid,
	output instr_decode_pkg::instr_t head_instr,
	output logic                     in_credit
);

	instr_decode_pkg::instr_t mem [instr_decode_pkg::QUEUE_DEPTH];
	instr_decode_pkg::q_ptr_t wr_ptr;
	instr_decode_pkg::q_ptr_t rd_ptr;
	instr_decode_pkg::q_cnt_t count;
	logic                     do_pop;

	function automatic instr_decode_pkg::q_ptr_t ptr_inc(input instr_decode_pkg::q_ptr_t p);
		if (p == instr_decode_pkg::q_ptr_t'(instr_decode_pkg::QUEUE_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head_instr = mem[rd_ptr];
	assign do_pop = pop && head_valid;

	// fetch only sends with a credit, so there is always room
	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= in_instr;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);

			case ({in_valid, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase

			// one credit back per word leaving, issued or dropped
			in_credit <= do_pop;
		end
	end

endmodule

`default_nettype wire

//--- design/decoded_instr_if.sv
`default_nettype none

interface decoded_instr_if;

	instr_decode_pkg::group_t      group;
	instr_decode_pkg::oper_t       oper;
	instr_decode_pkg::reg_idx_t    ra;
	instr_decode_pkg::reg_idx_t    rb;
	instr_decode_pkg::reg_idx_t    rc;
	instr_decode_pkg::imm_t        imm;
	logic                          nop;
	instr_decode_pkg::stall_type_t stall_type;
	// alu op that ignores the operand size
	logic                          forced_64;

	modport dec (
		output group,
		output oper,
		output ra,
		output rb,
		output rc,
		output imm,
		output nop,
		output stall_type,
		output forced_64
	);

	modport ctrl (
		input group,
		input oper,
		input ra,
		input rb,
		input rc,
		input imm,
		input nop,
		input stall_type,
		input forced_64
	);

endinterface

`default_nettype wire

//--- design/instr_decode_pkg.sv
`default_nettype none

package instr_decode_pkg;

	// basic widths
	localparam int INSTR_WIDTH = 32;
	localparam int IMM_WIDTH = 64;
	localparam int REG_IDX_WIDTH = 4;
	localparam int OPER_WIDTH = 4;
	localparam int NUM_REGS = 1 << REG_IDX_WIDTH;

	typedef logic [INSTR_WIDTH-1:0] instr_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	typedef logic [OPER_WIDTH-1:0] oper_t;
	typedef logic [IMM_WIDTH-1:0] imm_t;

	// codes 4 to 7 decode as no-ops
	typedef enum logic [2:0] {
		group_alu    = 3'd0,
		group_branch = 3'd1,
		group_load   = 3'd2,
		group_store  = 3'd3
	} group_t;

	typedef enum logic [1:0] {
		stall_none       = 2'd0,
		stall_ends_in_ex = 2'd1,
		stall_ends_in_wb = 2'd2
	} stall_type_t;

	// fields shared by every group
	localparam int GROUP_MSB = 31;
	localparam int GROUP_LSB = 29;
	localparam int RA_MSB = 28;
	localparam int RA_LSB = 25;

	// alu, load and store layout
	localparam int RB_MSB = 24;
	localparam int RB_LSB = 21;
	localparam int RC_MSB = 20;
	localparam int RC_LSB = 17;
	localparam int OPER_MSB = 16;
	localparam int OPER_LSB = 13;
	localparam int SIMM12_MSB = 11;

	// branch layout
	localparam int BR_OPER_MSB = 24;
	localparam int BR_OPER_LSB = 21;
	localparam int SIMM20_MSB = 19;

	// alu opers, 0 to 12 valid
	localparam oper_t ALU_OPER_LAST = 4'd12;
	localparam oper_t oper_div = 4'd6;
	localparam oper_t oper_shl = 4'd8;
	localparam oper_t oper_shr = 4'd9;
	localparam oper_t oper_not = 4'd11;
	localparam oper_t oper_bad_alu = 4'd15;

	localparam oper_t oper_bnz = 4'd0;
	localparam oper_t oper_bzo = 4'd1;
	localparam oper_t oper_jmp = 4'd2;

	// 0 to 7 plus the f16 variant are valid
	localparam oper_t oper_ld_f16 = 4'd8;
	localparam oper_t oper_st_f16 = 4'd8;

	// flow control
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
	localparam int EXEC_CREDITS = 2;
	localparam int CREDIT_CNT_WIDTH = $clog2(EXEC_CREDITS + 1);

	typedef logic [QUEUE_PTR_WIDTH-1:0] q_ptr_t;
	typedef logic [QUEUE_CNT_WIDTH-1:0] q_cnt_t;
	typedef logic [CREDIT_CNT_WIDTH-1:0] credit_cnt_t;

	typedef enum logic {
		st_run         = 1'b0,
		st_branch_wait = 1'b1
	} ctrl_state_t;

endpackage

`default_nettype wire
